/* design/ntsc_pkg.sv */
`default_nettype none

package ntsc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////////////////

  // One CCIR656 word on the 10-bit port and one captured component
  localparam int word_width   = 10;
  localparam int sample_width = 10;

  // Raster coordinates
  localparam int coord_x_width = 10;
  localparam int coord_y_width = 9;

  // Preamble of a timing code is 3FF 000 000
  localparam logic [word_width-1:0] code_preamble_ones = '1;
  localparam logic [word_width-1:0] code_preamble_zero = '0;

  // Lines above this are vertical blanking
  localparam logic [coord_y_width-1:0] line_limit = 9'd480;

  // Classifier thresholds on full 10-bit chroma
  localparam logic [sample_width-1:0] chroma_high = 10'd800;
  localparam logic [sample_width-1:0] chroma_low  = 10'd200;

  // Truncated widths inside a packed pixel pair
  localparam int packed_y_width = 8;
  localparam int packed_c_width = 5;

  //////////////////////////////////////////////////////////////////////
  // Shared types
  //////////////////////////////////////////////////////////////////////

  // Fourth word of a timing code, MSB first
  typedef struct packed {
    logic       one;
    logic       f;
    logic       v;
    logic       h;
    logic [3:0] protect;
    logic [1:0] pad;
  } timing_code_t;

  // Same port word, read as a sample or as a timing code
  typedef union packed {
    logic [word_width-1:0] sample;
    timing_code_t          code;
  } stream_word_u;

  typedef struct packed {
    logic [sample_width-1:0] y;
    logic [sample_width-1:0] cr;
    logic [sample_width-1:0] cb;
  } ycrcb_t;

  // Decoder output, one per Y word
  typedef struct packed {
    logic   valid;
    ycrcb_t pix;
  } pixel_beat_t;

  typedef struct packed {
    logic f;
    logic v;
    logic h;
  } sync_t;

  typedef struct packed {
    logic                     valid;
    ycrcb_t                   pix;
    logic [coord_x_width-1:0] x;
    logic [coord_y_width-1:0] y;
  } located_pixel_t;

  // 18-bit truncated pixel
  typedef struct packed {
    logic [packed_y_width-1:0] y;
    logic [packed_c_width-1:0] cr;
    logic [packed_c_width-1:0] cb;
  } pixel_half_t;

  typedef struct packed {
    pixel_half_t hi;
    pixel_half_t lo;
  } pixel_pair_t;

  // First word names Cr, second names Cb
  typedef enum logic [1:0] {
    high_high = 2'd0,
    low_high  = 2'd1,
    high_low  = 2'd2,
    low_low   = 2'd3
  } corner_e;

  typedef struct packed {
    logic                     valid;
    corner_e                  corner;
    logic [coord_x_width-1:0] x;
    logic [coord_y_width-1:0] y;
  } chroma_hit_t;

endpackage

`default_nettype wire

/* design/ccir656_decoder.sv */
`default_nettype none

module ccir656_decoder import ntsc_pkg::*;
(
  input  logic         clock_27mhz,
  input  logic         reset,
  input  stream_word_u tv_in_ycrcb,
  output pixel_beat_t  beat,
  output sync_t        sync
);

  //////////////////////////////////////////////////////////////////////
  // Stream FSM
  //////////////////////////////////////////////////////////////////////

  // Hunt states find 3FF 000 000, then one state reads the code word
  // Last four states walk the Cb Y Cr Y group of active video
  typedef enum logic [2:0] {
    st_hunt,
    st_zero_1,
    st_zero_2,
    st_code,
    st_cb,
    st_y0,
    st_cr,
    st_y1
  } state_e;

  state_e                  state;
  timing_code_t            code_w;
  logic                    is_ones;
  logic                    is_zero;
  logic                    code_ok;
  logic                    code_sav;
  logic                    in_y;
  logic                    valid_q;
  ycrcb_t                  pix_q;
  logic [sample_width-1:0] cr_q;
  logic [sample_width-1:0] cb_q;

  assign code_w  = tv_in_ycrcb.code;
  assign is_ones = tv_in_ycrcb.sample == code_preamble_ones;
  assign is_zero = tv_in_ycrcb.sample == code_preamble_zero;

  // Protection bits are P3=V^H P2=F^H P1=F^V P0=F^V^H
  assign code_ok = code_w.one &&
                   (code_w.protect == {code_w.v ^ code_w.h,
                                       code_w.f ^ code_w.h,
                                       code_w.f ^ code_w.v,
                                       code_w.f ^ code_w.v ^ code_w.h});

  // Start of active video, either field
  assign code_sav = code_ok && !code_w.v && !code_w.h;

  assign in_y = (state == st_y0) || (state == st_y1);

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      state <= st_hunt;
    end
    else
    begin
      unique case (state)
        st_hunt:   if (is_ones) state <= st_zero_1;
        st_zero_1: state <= is_zero ? st_zero_2 : (is_ones ? st_zero_1 : st_hunt);
        st_zero_2: state <= is_zero ? st_code : (is_ones ? st_zero_1 : st_hunt);
        // EAV, blanking and bad codes all go back to hunting
        st_code:   state <= code_sav ? st_cb : (is_ones ? st_zero_1 : st_hunt);
        // A 3FF inside the group is a new preamble, so resync on it
        st_cb:     state <= is_ones ? st_zero_1 : st_y0;
        st_y0:     state <= is_ones ? st_zero_1 : st_cr;
        st_cr:     state <= is_ones ? st_zero_1 : st_y1;
        st_y1:     state <= is_ones ? st_zero_1 : st_cb;
        default:   state <= st_hunt;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sync flags and beats
  //////////////////////////////////////////////////////////////////////

  // v and h pulse once per recognised code, f holds until the next one
  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      sync    <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      sync.v  <= 1'b0;
      sync.h  <= 1'b0;
      valid_q <= in_y && !is_ones;
      if (state == st_code && code_ok)
      begin
        sync <= '{f: code_w.f, v: code_w.v, h: code_w.h};
      end
    end
  end

  // Component capture, the beat pairs each Y with latest Cr and Cb
  always_ff @(posedge clock_27mhz)
  begin
    if (state == st_cb && !is_ones)
      cb_q <= tv_in_ycrcb.sample;
    if (state == st_cr && !is_ones)
      cr_q <= tv_in_ycrcb.sample;
    if (in_y && !is_ones)
      pix_q <= '{y: tv_in_ycrcb.sample, cr: cr_q, cb: cb_q};
  end

  assign beat = '{valid: valid_q, pix: pix_q};

  // Beats only ever follow a Y slot of the group
  assert property (@(posedge clock_27mhz) disable iff (reset)
    beat.valid |-> $past(state) inside {st_y0, st_y1});

endmodule

`default_nettype wire

/* design/raster_tracker.sv */
`default_nettype none

module raster_tracker import ntsc_pkg::*;
(
  input  logic           clock_27mhz,
  input  logic           reset,
  input  pixel_beat_t    beat,
  input  sync_t          sync,
  output located_pixel_t pixel,
  output logic           frame_flag
);

  logic [coord_x_width-1:0] x;
  logic [coord_y_width-1:0] y;
  logic                     in_active;
  logic                     fired;
  logic                     pixel_valid;
  ycrcb_t                   pixel_pix;
  logic [coord_x_width-1:0] pixel_x;
  logic [coord_y_width-1:0] pixel_y;

  // Lines past the limit are vertical blanking
  assign in_active = y <= line_limit;

  //////////////////////////////////////////////////////////////////////
  // Interlaced coordinates
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      x <= '0;
      y <= '0;
    end
    else if (sync.h)
    begin
      // Next line of the same field, h wins when both are set
      x <= '0;
      y <= y + 2'd2;
    end
    else if (sync.v)
    begin
      // Even field (f high) starts on line 0, odd field on line 1
      x <= '0;
      y <= {{(coord_y_width-1){1'b0}}, ~sync.f};
    end
    else if (beat.valid && in_active)
    begin
      x <= x + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pixel gating and field start
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      pixel_valid <= 1'b0;
      frame_flag  <= 1'b0;
      fired       <= 1'b0;
    end
    else
    begin
      pixel_valid <= beat.valid && in_active;
      frame_flag  <= 1'b0;
      // Odd field rearms the pulse
      if (!sync.f)
        fired <= 1'b0;
      else if ((sync.v || y >= line_limit) && !fired)
      begin
        frame_flag <= 1'b1;
        fired      <= 1'b1;
      end
    end
  end

  // Location of each beat is the count before the increment
  always_ff @(posedge clock_27mhz)
  begin
    if (beat.valid)
    begin
      pixel_pix <= beat.pix;
      pixel_x   <= x;
      pixel_y   <= y;
    end
  end

  assign pixel = '{valid: pixel_valid, pix: pixel_pix, x: pixel_x, y: pixel_y};

  // Every located pixel lies in the visible lines
  assert property (@(posedge clock_27mhz) disable iff (reset)
    pixel.valid |-> pixel.y <= line_limit);

endmodule

`default_nettype wire

/* design/pixel_pair_packer.sv */
`default_nettype none

module pixel_pair_packer import ntsc_pkg::*;
(
  input  logic           clock_27mhz,
  input  logic           reset,
  input  located_pixel_t pixel,
  output pixel_pair_t    pair,
  output logic           pair_valid
);

  // Low when the next pixel goes into the low half
  logic        phase;
  pixel_half_t half;

  // Keep the top bits of each component
  assign half = '{
    y:  pixel.pix.y[sample_width-1 -: packed_y_width],
    cr: pixel.pix.cr[sample_width-1 -: packed_c_width],
    cb: pixel.pix.cb[sample_width-1 -: packed_c_width]
  };

  //////////////////////////////////////////////////////////////////////
  // Pairing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
    begin
      phase      <= 1'b0;
      pair_valid <= 1'b0;
    end
    else
    begin
      // Pair is complete once the high half is written
      pair_valid <= pixel.valid && phase;
      if (pixel.valid)
        phase <= ~phase;
    end
  end

  always_ff @(posedge clock_27mhz)
  begin
    if (pixel.valid)
    begin
      if (phase)
        pair.hi <= half;
      else
        pair.lo <= half;
    end
  end

  // Two pixels per pair, so flags are at least two cycles apart
  assert property (@(posedge clock_27mhz) disable iff (reset)
    pair_valid |=> !pair_valid);

endmodule

`default_nettype wire

/* design/chroma_classifier.sv */
`default_nettype none

module chroma_classifier import ntsc_pkg::*;
(
  input  logic           clock_27mhz,
  input  logic           reset,
  input  located_pixel_t pixel,
  output chroma_hit_t    hit
);

  logic                     cr_high;
  logic                     cr_low;
  logic                     cb_high;
  logic                     cb_low;
  logic                     match;
  corner_e                  corner;
  logic                     hit_valid;
  corner_e                  hit_corner;
  logic [coord_x_width-1:0] hit_x;
  logic [coord_y_width-1:0] hit_y;

  // Strict comparisons, values on a threshold fall in the middle band
  assign cr_high = pixel.pix.cr > chroma_high;
  assign cr_low  = pixel.pix.cr < chroma_low;
  assign cb_high = pixel.pix.cb > chroma_high;
  assign cb_low  = pixel.pix.cb < chroma_low;

  //////////////////////////////////////////////////////////////////////
  // Corner select
  //////////////////////////////////////////////////////////////////////

  // First match in the order hh, lh, hl, ll
  always_comb
  begin
    match  = 1'b1;
    corner = high_high;
    if (cr_high && cb_high)
      corner = high_high;
    else if (cr_low && cb_high)
      corner = low_high;
    else if (cr_high && cb_low)
      corner = high_low;
    else if (cr_low && cb_low)
      corner = low_low;
    else
      match = 1'b0;
  end

  always_ff @(posedge clock_27mhz)
  begin
    if (reset)
      hit_valid <= 1'b0;
    else
      hit_valid <= pixel.valid && match;
  end

  // Corner and location only change on a hit
  always_ff @(posedge clock_27mhz)
  begin
    if (pixel.valid && match)
    begin
      hit_corner <= corner;
      hit_x      <= pixel.x;
      hit_y      <= pixel.y;
    end
  end

  assign hit = '{valid: hit_valid, corner: hit_corner, x: hit_x, y: hit_y};

endmodule

`default_nettype wire

/* design/ntsc_capture.sv */
`default_nettype none

module ntsc_capture import ntsc_pkg::*;
(
  input  logic         clock_27mhz,
  input  logic         reset,
  input  stream_word_u tv_in_ycrcb,
  output pixel_pair_t  ntsc_pixels,
  output logic         ntsc_flag,
  output chroma_hit_t  hit,
  output logic         frame_flag
);

  // Stage to stage buses
  pixel_beat_t    beat;
  sync_t          sync;
  located_pixel_t pixel;

  // Word stream to pixel beats and sync pulses
  ccir656_decoder i_decoder (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .tv_in_ycrcb (tv_in_ycrcb),
    .beat        (beat),
    .sync        (sync)
  );

  // Coordinates, blanking and field start
  raster_tracker i_tracker (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .beat        (beat),
    .sync        (sync),
    .pixel       (pixel),
    .frame_flag  (frame_flag)
  );

  // Packer and classifier run side by side on the same pixels
  pixel_pair_packer i_packer (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .pixel       (pixel),
    .pair        (ntsc_pixels),
    .pair_valid  (ntsc_flag)
  );

  chroma_classifier i_classifier (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .pixel       (pixel),
    .hit         (hit)
  );

endmodule

`default_nettype wire

/* verification/tb_ntsc_capture.sv */
`default_nettype none

module tb_ntsc_capture
  import ntsc_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // Constants and stream table format
  //////////////////////////////////////////////////////////////////////

  localparam int num_rows     = 29;
  localparam int exp_depth    = 4096;
  localparam int reset_cycles = 16;
  localparam int drain_cycles = 200;

  // Role of a word within the Cb Y Cr Y group
  localparam int role_other = 0;
  localparam int role_cb    = 1;
  localparam int role_cr    = 2;
  localparam int role_y     = 3;

  // Chroma bands, corner names give Cr first
  localparam logic [2:0] band_any = 3'd0;
  localparam logic [2:0] band_hh  = 3'd1;
  localparam logic [2:0] band_lh  = 3'd2;
  localparam logic [2:0] band_hl  = 3'd3;
  localparam logic [2:0] band_ll  = 3'd4;
  localparam logic [2:0] band_mid = 3'd5;

  // One table row, a code then groups, repeated reps times
  typedef struct packed {
    logic       f;
    logic       v;
    logic       h;
    logic [7:0] groups;
    logic       inject;
    logic [8:0] reps;
    logic [2:0] band;
  } row_t;

  logic         clock_27mhz;
  logic         reset;
  stream_word_u tv_in_ycrcb;
  pixel_pair_t  ntsc_pixels;
  logic         ntsc_flag;
  chroma_hit_t  hit;
  logic         frame_flag;

  row_t        stream_table [num_rows];
  logic        exp_pair_valid [exp_depth];
  pixel_pair_t exp_pair [exp_depth];
  chroma_hit_t exp_hit [exp_depth];
  logic        exp_frame [exp_depth];

  // Reference model state
  logic [31:0]              rng;
  int                       cycle = 0;
  int                       cycle_limit = 1 << 30;
  int                       last_edge;
  int                       last_expect;
  logic                     active_m;
  logic [sample_width-1:0]  cr_m;
  logic [sample_width-1:0]  cb_m;
  pixel_half_t              lo_m;
  logic                     phase_m;
  logic [coord_x_width-1:0] x_m;
  logic [coord_y_width-1:0] y_m;
  logic                     fired_m;
  int                       value_errors;
  int                       missing_errors;
  int                       extra_errors;

  ntsc_capture i_dut (
    .clock_27mhz (clock_27mhz),
    .reset       (reset),
    .tv_in_ycrcb (tv_in_ycrcb),
    .ntsc_pixels (ntsc_pixels),
    .ntsc_flag   (ntsc_flag),
    .hit         (hit),
    .frame_flag  (frame_flag)
  );

  always #2 clock_27mhz = ~clock_27mhz;

  always @(posedge clock_27mhz)
    cycle <= cycle + 1;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  function automatic logic [word_width-1:0] rand_range(input int base, input int span);
    int value;
    rng   = xorshift(rng);
    value = base + int'(rng % span);
    return value[word_width-1:0];
  endfunction

  // Samples stay in 4..1019 so they never match a preamble word
  function automatic logic [word_width-1:0] chroma_value(input logic [2:0] band,
                                                         input logic is_cr);
    logic high;
    if (band == band_any)
      return rand_range(4, 1016);
    if (band == band_mid)
      return rand_range(200, 601);
    // Cr high in hh and hl, Cb high in hh and lh
    high = is_cr ? (band == band_hh || band == band_hl)
                 : (band == band_hh || band == band_lh);
    if (high)
      return rand_range(801, 219);
    return rand_range(4, 196);
  endfunction

  // CCIR656 code word with its protection bits
  function automatic logic [word_width-1:0] code_word(input logic f, input logic v,
                                                      input logic h);
    return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h, 2'b00};
  endfunction

  // Expected corner by threshold rules, first match wins
  function automatic logic corner_of(input logic [sample_width-1:0] cr,
                                     input logic [sample_width-1:0] cb,
                                     output corner_e c);
    logic crh;
    logic crl;
    logic cbh;
    logic cbl;
    crh = cr > chroma_high;
    crl = cr < chroma_low;
    cbh = cb > chroma_high;
    cbl = cb < chroma_low;
    c = high_high;
    if (crh && cbh)
      return 1'b1;
    c = low_high;
    if (crl && cbh)
      return 1'b1;
    c = high_low;
    if (crh && cbl)
      return 1'b1;
    c = low_low;
    return crl && cbl;
  endfunction

  function automatic row_t make_row(input logic f, input logic v, input logic h,
                                    input logic [7:0] groups, input logic inject,
                                    input logic [8:0] reps, input logic [2:0] band);
    return {f, v, h, groups, inject, reps, band};
  endfunction

  task automatic load_table();
    // f v h  groups inject reps band
    stream_table[0]  = make_row(1, 1, 0, 2, 0, 1, band_mid);   // even v, data ignored
    stream_table[1]  = make_row(1, 0, 0, 6, 0, 1, band_mid);   // line 0
    stream_table[2]  = make_row(1, 0, 1, 1, 0, 1, band_any);   // EAV then data
    stream_table[3]  = make_row(1, 0, 0, 4, 0, 1, band_hh);
    stream_table[4]  = make_row(1, 0, 1, 0, 0, 1, band_any);
    stream_table[5]  = make_row(1, 0, 0, 4, 0, 1, band_lh);
    stream_table[6]  = make_row(1, 0, 1, 0, 0, 1, band_any);
    stream_table[7]  = make_row(1, 0, 0, 4, 1, 1, band_hl);    // resync mid line
    stream_table[8]  = make_row(1, 0, 1, 0, 0, 1, band_any);
    stream_table[9]  = make_row(1, 0, 0, 4, 0, 1, band_ll);
    stream_table[10] = make_row(1, 0, 1, 0, 0, 1, band_any);
    stream_table[11] = make_row(1, 0, 0, 5, 0, 1, band_any);
    stream_table[12] = make_row(1, 0, 1, 0, 0, 1, band_any);
    stream_table[13] = make_row(0, 1, 0, 0, 0, 1, band_any);   // odd v, line 1
    stream_table[14] = make_row(0, 0, 0, 5, 0, 1, band_any);
    stream_table[15] = make_row(0, 0, 1, 0, 0, 240, band_any); // up to line 481
    stream_table[16] = make_row(0, 0, 0, 3, 0, 1, band_any);   // blanking, dropped
    stream_table[17] = make_row(0, 0, 1, 0, 0, 1, band_any);
    stream_table[18] = make_row(1, 1, 0, 0, 0, 1, band_any);   // even v
    stream_table[19] = make_row(1, 1, 0, 0, 0, 1, band_any);   // same field again
    stream_table[20] = make_row(1, 0, 0, 3, 0, 1, band_any);
    stream_table[21] = make_row(1, 0, 1, 0, 0, 240, band_any); // up to line 480
    stream_table[22] = make_row(1, 0, 0, 2, 0, 1, band_any);   // last visible line
    stream_table[23] = make_row(1, 0, 1, 0, 0, 1, band_any);
    stream_table[24] = make_row(1, 0, 0, 2, 0, 1, band_any);   // line 482, dropped
    stream_table[25] = make_row(0, 1, 0, 0, 0, 1, band_any);
    stream_table[26] = make_row(1, 1, 0, 0, 0, 1, band_any);
    stream_table[27] = make_row(1, 0, 0, 4, 1, 1, band_any);
    stream_table[28] = make_row(1, 0, 1, 1, 0, 1, band_any);   // ends in hunting
  endtask

  function automatic int count_words();
    int n;
    n = 1;
    for (int r = 0; r < num_rows; r++)
    begin
      n += stream_table[r].reps * (4 + 4 * stream_table[r].groups +
           ((stream_table[r].inject && stream_table[r].groups != 0) ? 1 : 0));
    end
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Pixel of a Y word driven at edge t-4, seen at the outputs at cycle t
  task automatic emit_pixel(input int t, input logic [sample_width-1:0] luma);
    pixel_half_t half;
    corner_e     c;
    half = {luma[sample_width-1 -: packed_y_width],
            cr_m[sample_width-1 -: packed_c_width],
            cb_m[sample_width-1 -: packed_c_width]};
    if (!phase_m)
      lo_m = half;
    else
    begin
      exp_pair_valid[t] = 1'b1;
      exp_pair[t]       = {half, lo_m};
    end
    phase_m = ~phase_m;
    if (corner_of(cr_m, cb_m, c))
      exp_hit[t] = {1'b1, c, x_m, y_m};
    x_m = x_m + 1'b1;
    if (t > last_expect)
      last_expect = t;
  endtask

  // Tracker acts on a code two edges after it is driven
  task automatic apply_code(input int d, input logic f, input logic v, input logic h);
    if (!f)
      fired_m = 1'b0;
    else if ((v || y_m >= line_limit) && !fired_m)
    begin
      exp_frame[d + 3] = 1'b1;
      fired_m          = 1'b1;
    end
    if (h)
    begin
      x_m = '0;
      y_m = y_m + 2'd2;
    end
    else if (v)
    begin
      x_m = '0;
      y_m = {{(coord_y_width-1){1'b0}}, ~f};
    end
    // New line count may cross the limit one cycle later
    if (f && !fired_m && y_m >= line_limit)
    begin
      exp_frame[d + 4] = 1'b1;
      fired_m          = 1'b1;
    end
    active_m = !v && !h;
    if (d + 4 > last_expect)
      last_expect = d + 4;
  endtask

  task automatic drive_word(input logic [word_width-1:0] w, input int role);
    int d;
    @(posedge clock_27mhz);
    d = cycle;
    tv_in_ycrcb.sample <= w;
    last_edge = d;
    if (w == code_preamble_ones)
      active_m = 1'b0;
    if (active_m && role == role_cb)
      cb_m = w;
    if (active_m && role == role_cr)
      cr_m = w;
    if (active_m && role == role_y && y_m <= line_limit)
      emit_pixel(d + 4, w);
  endtask

  task automatic insert_code(input logic f, input logic v, input logic h);
    drive_word(code_preamble_ones, role_other);
    drive_word(code_preamble_zero, role_other);
    drive_word(code_preamble_zero, role_other);
    drive_word(code_word(f, v, h), role_other);
    apply_code(last_edge, f, v, h);
  endtask

  task automatic play_row(input row_t r);
    for (int k = 0; k < r.reps; k++)
    begin
      insert_code(r.f, r.v, r.h);
      for (int g = 0; g < r.groups; g++)
      begin
        if (r.inject && g == r.groups / 2)
          drive_word(code_preamble_ones, role_other);
        drive_word(chroma_value(r.band, 1'b0), role_cb);
        drive_word(rand_range(4, 1016), role_y);
        drive_word(chroma_value(r.band, 1'b1), role_cr);
        drive_word(rand_range(4, 1016), role_y);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clock_27mhz)
  begin
    if (!reset && cycle < exp_depth)
    begin
      if (ntsc_flag !== exp_pair_valid[cycle])
      begin
        if (exp_pair_valid[cycle])
        begin
          missing_errors++;
          $display("Missing pixel pair at time %0t", $time);
        end
        else
        begin
          extra_errors++;
          $display("Unexpected pixel pair at time %0t", $time);
        end
      end
      else if (ntsc_flag && ntsc_pixels !== exp_pair[cycle])
      begin
        value_errors++;
        $display("FAILED at %0t: pair %h, expected %h", $time, ntsc_pixels, exp_pair[cycle]);
      end
      if (hit.valid !== exp_hit[cycle].valid)
      begin
        if (exp_hit[cycle].valid)
        begin
          missing_errors++;
          $display("Missing chroma hit at time %0t", $time);
        end
        else
        begin
          extra_errors++;
          $display("Unexpected chroma hit at time %0t", $time);
        end
      end
      else if (hit.valid && hit !== exp_hit[cycle])
      begin
        value_errors++;
        $display("FAILED at %0t: hit corner %0d x %0d y %0d, expected %0d x %0d y %0d",
                 $time, hit.corner, hit.x, hit.y,
                 exp_hit[cycle].corner, exp_hit[cycle].x, exp_hit[cycle].y);
      end
      if (frame_flag !== exp_frame[cycle])
      begin
        if (exp_frame[cycle])
        begin
          missing_errors++;
          $display("Missing frame_flag pulse at time %0t", $time);
        end
        else
        begin
          extra_errors++;
          $display("Unexpected frame_flag pulse at time %0t", $time);
        end
      end
    end
  end

  // Run limit from the stream length
  always @(posedge clock_27mhz)
  begin
    if (cycle >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the stream never finished", cycle);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int total_words;
    clock_27mhz        = 1'b0;
    reset              = 1'b1;
    tv_in_ycrcb.sample = 10'h200;
    rng                = 32'hdb2f_5c33;
    last_edge          = 0;
    last_expect        = 0;
    active_m           = 1'b0;
    // Decoder Cr register is unknown until the first Cr word
    cr_m               = 'x;
    cb_m               = 'x;
    lo_m               = '0;
    phase_m            = 1'b0;
    x_m                = '0;
    y_m                = '0;
    fired_m            = 1'b0;
    value_errors       = 0;
    missing_errors     = 0;
    extra_errors       = 0;
    for (int i = 0; i < exp_depth; i++)
    begin
      exp_pair_valid[i] = 1'b0;
      exp_pair[i]       = '0;
      exp_hit[i]        = '0;
      exp_frame[i]      = 1'b0;
    end
    load_table();
    total_words = count_words();
    cycle_limit = reset_cycles + total_words + drain_cycles;
    repeat (reset_cycles) @(posedge clock_27mhz);
    reset <= 1'b0;
    for (int r = 0; r < num_rows; r++)
      play_row(stream_table[r]);
    drive_word(10'h200, role_other);
    // Outputs trail the stream by the fixed pipeline latency
    while (cycle <= last_expect + 1)
      @(negedge clock_27mhz);
    $display("Errors: %0d wrong values, %0d missing outputs, %0d unexpected outputs",
             value_errors, missing_errors, extra_errors);
    if (value_errors + missing_errors + extra_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
design/ntsc_pkg.sv
design/ccir656_decoder.sv
design/raster_tracker.sv
design/pixel_pair_packer.sv
design/chroma_classifier.sv
design/ntsc_capture.sv
verification/tb_ntsc_capture.sv

/* Bender.yml */
package:
  name: ntsc_capture

sources:
  - design/ntsc_pkg.sv
  - design/ccir656_decoder.sv
  - design/raster_tracker.sv
  - design/pixel_pair_packer.sv
  - design/chroma_classifier.sv
  - design/ntsc_capture.sv
  - target: simulation
    files:
      - verification/tb_ntsc_capture.sv
